/* ahb_in_stage.f */
src/ahb_in_pkg.sv
src/ahb_hold_reg.sv
src/ahb_pend_ctrl.sv
src/ahb_burst_fix.sv
src/ahb_in_stage.sv
verification/ahb_in_stage_clk_gen.sv
verification/ahb_in_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the AHB input stage testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --top-module ahb_in_stage_tb \
  --Mdir "$BUILD_DIR" \
  -f ahb_in_stage.f

"./$BUILD_DIR/Vahb_in_stage_tb" | tee "$LOG"

# The log decides, the simulator exit code is lost in the pipe
if grep -q "Simulation finished: PASS" "$LOG"; then
  echo "Result: passed"
else
  echo "Result: failed"
  exit 1
fi

/* verification/ahb_in_stage_tb.sv */
module ahb_in_stage_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import ahb_in_pkg::*;

  localparam int unsigned num_tests  = 5;
  localparam int unsigned clk_period = 4;
  localparam int unsigned timeout_ns = num_tests * 60 * clk_period + 100;

  localparam ahb_resp_t resp_ok   = '{ready: 1'b1, resp: rsp_okay};
  localparam ahb_resp_t resp_wait = '{ready: 1'b0, resp: rsp_okay};   // Wait state
  localparam ahb_resp_t resp_err  = '{ready: 1'b1, resp: rsp_error};
  localparam ahb_resp_t resp_bad  = '{ready: 1'b0, resp: rsp_error};  // Must never leak
  localparam ahb_addr_t addr_idle = '0;                                // Not selected, IDLE

  logic        HCLK;
  logic        HRESETn;
  ahb_addr_t   s_addr;
  logic        HREADYS;
  logic        active_ip;
  ahb_resp_t   m_resp;
  ahb_resp_t   s_resp;
  ahb_addr_t   m_addr;
  logic        held_tran_ip;
  string       test_name;
  int unsigned test_errors;
  int unsigned total_errors;
  int unsigned tests_failed;
  logic [15:0] lfsr_state = 16'd66;  // x^16 + x^14 + x^13 + x^11 + 1

  ahb_in_stage_clk_gen u_clk_gen (.HCLK(HCLK), .HRESETn(HRESETn));

  ahb_in_stage ahb_in_stage_i (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .s_addr       (s_addr),
    .HREADYS      (HREADYS),
    .s_resp       (s_resp),
    .active_ip    (active_ip),
    .m_resp       (m_resp),
    .m_addr       (m_addr),
    .held_tran_ip (held_tran_ip)
  );

  // ------------------------------
  // Stimulus helpers
  // ------------------------------

  function automatic logic lfsr_next_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(input int unsigned count);
    logic [31:0] value;
    value = '0;
    for (int unsigned i = 0; i < count; i++)
    begin
      value = {value[30:0], lfsr_next_bit()};  // One step per bit
    end
    return value;
  endfunction

  function automatic ahb_addr_t make_addr(input htrans_e trans, input logic [31:0] addr,
                                          input hburst_e burst, input logic [2:0] size,
                                          input logic write);
    ahb_addr_t a;
    a       = '0;
    a.sel   = 1'b1;
    a.trans = trans;
    a.addr  = addr;
    a.write = write;
    a.size  = size;
    a.burst = burst;
    a.prot  = 4'b0011;  // Privileged data access
    return a;
  endfunction

  // Parked transfer as the slave sees it
  function automatic ahb_addr_t as_held(input ahb_addr_t a);
    a.sel   = 1'b1;
    a.trans = trn_nonseq;
    return a;
  endfunction

  function automatic ahb_addr_t with_burst(input ahb_addr_t a, input hburst_e burst);
    a.burst = burst;
    return a;
  endfunction

  function automatic ahb_addr_t with_trans(input ahb_addr_t a, input htrans_e trans);
    a.trans = trans;
    return a;
  endfunction

  task automatic next_cycle();
    @(posedge HCLK);
    #1;  // Drive point
  endtask

  task automatic drive(input ahb_addr_t a, input logic ready, input logic active,
                       input ahb_resp_t r);
    s_addr    = a;
    HREADYS   = ready;
    active_ip = active;
    m_resp    = r;
    #1;  // Sample point, well before the next edge
  endtask

  task automatic idle_cycles();
    drive(addr_idle, 1'b1, 1'b1, resp_ok);
    next_cycle();
    drive(addr_idle, 1'b1, 1'b1, resp_ok);
    next_cycle();
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------

  task automatic check_addr(input ahb_addr_t exp, input ahb_addr_t act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: m_addr expected %h, actual %h", test_name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_resp(input ahb_resp_t exp, input ahb_resp_t act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: s_resp expected %h, actual %h", test_name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_bit(input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: held_tran_ip expected %b, actual %b", test_name, exp, act);
      test_errors++;
    end
  endtask

  task automatic expect_outputs(input ahb_addr_t exp_addr, input logic exp_req,
                                input ahb_resp_t exp_resp);
    check_addr(exp_addr, m_addr);
    check_bit(exp_req, held_tran_ip);
    check_resp(exp_resp, s_resp);
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    if (test_errors == 0)
    begin
      $display("%s: passed", test_name);
    end
    else
    begin
      $display("%s: failed with %0d errors", test_name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic test_pass_through();
    ahb_addr_t wr;
    ahb_addr_t rd;
    begin_test("pass_through");
    wr = make_addr(trn_nonseq, random_bits(32), bur_single, 3'b000, 1'b1);
    rd = make_addr(trn_nonseq, random_bits(30) << 2, bur_single, 3'b010, 1'b0);
    drive(wr, 1'b1, 1'b1, resp_ok);
    expect_outputs(wr, 1'b1, resp_ok);  // Same cycle, load raises request
    next_cycle();
    drive(rd, 1'b1, 1'b1, resp_err);
    expect_outputs(rd, 1'b1, resp_err);  // Error of slave reaches master
    next_cycle();
    drive(addr_idle, 1'b0, 1'b1, resp_wait);
    expect_outputs(addr_idle, 1'b0, resp_wait);  // Slave wait state
    next_cycle();
    drive(addr_idle, 1'b1, 1'b1, resp_ok);
    expect_outputs(addr_idle, 1'b0, resp_ok);
    next_cycle();
    idle_cycles();
    end_test();
  endtask

  task automatic test_hold_busy();
    ahb_addr_t a;
    begin_test("hold_busy");
    a = make_addr(trn_nonseq, random_bits(30) << 2, bur_single, 3'b010, 1'b1);
    drive(a, 1'b1, 1'b0, resp_ok);
    expect_outputs(a, 1'b1, resp_ok);  // Still live in the load cycle
    next_cycle();
    drive(addr_idle, 1'b0, 1'b0, resp_ok);
    expect_outputs(as_held(a), 1'b1, resp_wait);
    next_cycle();
    drive(addr_idle, 1'b0, 1'b1, resp_wait);  // Granted, slave not ready
    expect_outputs(as_held(a), 1'b1, resp_wait);
    next_cycle();
    drive(addr_idle, 1'b0, 1'b1, resp_ok);  // Release edge ends this cycle
    expect_outputs(as_held(a), 1'b1, resp_wait);
    next_cycle();
    drive(addr_idle, 1'b1, 1'b1, resp_ok);
    expect_outputs(addr_idle, 1'b0, resp_ok);  // Back to pass-through
    next_cycle();
    idle_cycles();
    end_test();
  endtask

  task automatic test_idle_response();
    ahb_addr_t cases [3];
    begin_test("idle_response");
    cases[0]     = make_addr(trn_nonseq, random_bits(32), bur_single, 3'b000, 1'b0);
    cases[0].sel = 1'b0;
    cases[1]     = make_addr(trn_idle, random_bits(32), bur_single, 3'b000, 1'b0);
    cases[2]     = make_addr(trn_busy, random_bits(32), bur_incr, 3'b000, 1'b1);
    foreach (cases[i])
    begin
      drive(cases[i], 1'b1, 1'b1, resp_ok);
      expect_outputs(cases[i], 1'b0, resp_ok);
      next_cycle();
      drive(addr_idle, 1'b1, 1'b1, resp_bad);
      expect_outputs(addr_idle, 1'b0, resp_ok);  // No data phase, m_resp ignored
      next_cycle();
    end
    end_test();
  endtask

  task automatic test_burst_override();
    logic [31:0] base;
    logic [31:0] base2;
    ahb_addr_t   beat [4];
    ahb_addr_t   n1;
    ahb_addr_t   t1;
    begin_test("burst_override");
    base  = random_bits(28) << 4;
    base2 = random_bits(28) << 4;
    beat[0] = make_addr(trn_nonseq, base, bur_incr4, 3'b010, 1'b1);
    for (int unsigned i = 1; i < 4; i++)
    begin
      beat[i] = make_addr(trn_seq, base + 32'd4 * i, bur_incr4, 3'b010, 1'b1);
    end
    n1 = make_addr(trn_nonseq, base2, bur_incr4, 3'b010, 1'b0);
    t1 = make_addr(trn_seq, base2 + 32'd4, bur_incr4, 3'b010, 1'b0);
    drive(beat[0], 1'b1, 1'b1, resp_ok);
    expect_outputs(beat[0], 1'b1, resp_ok);
    next_cycle();
    drive(beat[1], 1'b1, 1'b0, resp_ok);  // Output stage drops us mid burst
    expect_outputs(beat[1], 1'b1, resp_ok);
    next_cycle();
    drive(beat[2], 1'b0, 1'b0, resp_ok);
    expect_outputs(with_burst(as_held(beat[1]), bur_incr), 1'b1, resp_wait);
    next_cycle();
    drive(beat[2], 1'b0, 1'b1, resp_ok);
    expect_outputs(with_burst(as_held(beat[1]), bur_incr), 1'b1, resp_wait);
    next_cycle();
    drive(beat[2], 1'b1, 1'b1, resp_ok);
    expect_outputs(with_burst(beat[2], bur_incr), 1'b1, resp_ok);
    next_cycle();
    drive(beat[3], 1'b1, 1'b1, resp_ok);
    expect_outputs(with_burst(beat[3], bur_incr), 1'b1, resp_ok);
    next_cycle();
    drive(n1, 1'b1, 1'b1, resp_ok);
    expect_outputs(n1, 1'b1, resp_ok);  // NONSEQ keeps its own burst
    next_cycle();
    drive(t1, 1'b1, 1'b1, resp_ok);
    expect_outputs(t1, 1'b1, resp_ok);  // Override cleared
    next_cycle();
    idle_cycles();
    end_test();
  endtask

  task automatic test_wrap_boundary();
    logic [31:0] base;
    ahb_addr_t   w0;
    ahb_addr_t   w1;
    ahb_addr_t   w2;
    ahb_addr_t   w3;
    begin_test("wrap_boundary");
    base = random_bits(28) << 4;  // 16 byte wrap window
    w0 = make_addr(trn_nonseq, base + 32'd4, bur_wrap4, 3'b010, 1'b0);
    w1 = make_addr(trn_seq, base + 32'd8, bur_wrap4, 3'b010, 1'b0);
    w2 = make_addr(trn_seq, base + 32'd12, bur_wrap4, 3'b010, 1'b0);  // Word offset 3
    w3 = make_addr(trn_seq, base, bur_wrap4, 3'b010, 1'b0);           // Wrapped beat
    drive(w0, 1'b1, 1'b1, resp_ok);
    expect_outputs(w0, 1'b1, resp_ok);
    next_cycle();
    drive(w1, 1'b1, 1'b0, resp_ok);
    expect_outputs(w1, 1'b1, resp_ok);
    next_cycle();
    drive(w2, 1'b0, 1'b0, resp_ok);
    expect_outputs(with_burst(as_held(w1), bur_incr), 1'b1, resp_wait);
    next_cycle();
    drive(w2, 1'b0, 1'b1, resp_ok);
    expect_outputs(with_burst(as_held(w1), bur_incr), 1'b1, resp_wait);
    next_cycle();
    drive(w2, 1'b1, 1'b1, resp_ok);
    expect_outputs(with_burst(w2, bur_incr), 1'b1, resp_ok);
    next_cycle();
    drive(w3, 1'b1, 1'b1, resp_ok);
    expect_outputs(with_trans(with_burst(w3, bur_incr), trn_nonseq), 1'b1, resp_ok);
    next_cycle();
    idle_cycles();
    end_test();
  endtask

  // ------------------------------
  // Sequencing and watchdog
  // ------------------------------

  initial
  begin
    s_addr       = addr_idle;
    HREADYS      = 1'b1;
    active_ip    = 1'b1;
    m_resp       = resp_ok;
    total_errors = 0;
    tests_failed = 0;
    @(posedge HRESETn);
    next_cycle();
    test_pass_through();
    test_hold_busy();
    test_idle_response();
    test_burst_override();
    test_wrap_boundary();
    $display("Tests: %0d run, %0d failed, %0d check errors",
             num_tests, tests_failed, total_errors);
    if (total_errors == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial
  begin
    #(timeout_ns);
    $display("Run timed out after %0d ns before all tests finished", timeout_ns);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* verification/ahb_in_stage_clk_gen.sv */
module ahb_in_stage_clk_gen (
  output logic HCLK,     // 4 ns AHB clock
  output logic HRESETn   // Sync reset, active low
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned half_period  = 2;  // 4 ns period
  localparam int unsigned reset_cycles = 2;

  initial
  begin
    HCLK = 1'b0;
    forever
    begin
      #(half_period) HCLK = ~HCLK;
    end
  end

  // Release just after an edge, like every other stimulus
  initial
  begin
    HRESETn = 1'b0;
    repeat (reset_cycles) @(posedge HCLK);
    #1 HRESETn = 1'b1;
  end

endmodule

/* src/ahb_in_stage.sv */
module ahb_in_stage (
  input  logic                  HCLK,          // AHB clock
  input  logic                  HRESETn,       // Sync reset, active low

  // Slave port from the master
  input  ahb_in_pkg::ahb_addr_t s_addr,        // HSELS, HTRANSS, HADDRS and the rest
  input  logic                  HREADYS,       // Bus-wide HREADY
  output ahb_in_pkg::ahb_resp_t s_resp,        // HREADYOUTS and HRESPS

  // Output stage side
  input  logic                  active_ip,     // Output stage currently serving us
  input  ahb_in_pkg::ahb_resp_t m_resp,        // readyout_ip and resp_ip
  output ahb_in_pkg::ahb_addr_t m_addr,        // Address phase towards the slave
  output logic                  held_tran_ip   // Request line to the arbiter
);

  import ahb_in_pkg::*;

  // ------------------------------
  // Internal nets
  // ------------------------------

  logic      load;        // Transfer accepted from master
  logic      pend;        // Holding register in use
  ahb_addr_t held_addr;   // Live or held address phase
  htrans_e   held_trans;  // Original trans for burst decision

  // ------------------------------
  // Hold control and response
  // ------------------------------

  ahb_pend_ctrl u_pend_ctrl (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .s_addr       (s_addr),
    .HREADYS      (HREADYS),
    .active_ip    (active_ip),
    .m_resp       (m_resp),
    .load         (load),
    .pend         (pend),
    .held_tran_ip (held_tran_ip),
    .s_resp       (s_resp)
  );

  // Holding register and select
  ahb_hold_reg u_hold_reg (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .s_addr     (s_addr),
    .load       (load),
    .pend       (pend),
    .held_addr  (held_addr),
    .held_trans (held_trans)
  );

  // ------------------------------
  // Burst correction
  // ------------------------------

  // Rewrites trans and burst only, all other fields pass unchanged
  ahb_burst_fix u_burst_fix (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .s_addr     (s_addr),
    .HREADYS    (HREADYS),
    .load       (load),
    .active_ip  (active_ip),
    .held_addr  (held_addr),
    .held_trans (held_trans),
    .m_addr     (m_addr)
  );

endmodule

/* src/ahb_burst_fix.sv */
module ahb_burst_fix (
  input  logic                  HCLK,        // AHB clock
  input  logic                  HRESETn,     // Sync reset, active low
  input  ahb_in_pkg::ahb_addr_t s_addr,      // Live address phase
  input  logic                  HREADYS,     // Bus-wide HREADY
  input  logic                  load,        // Transfer accepted this cycle
  input  logic                  active_ip,   // Output stage serving this port
  input  ahb_in_pkg::ahb_addr_t held_addr,   // Live or held address phase
  input  ahb_in_pkg::htrans_e   held_trans,  // Trans before NONSEQ forcing
  output ahb_in_pkg::ahb_addr_t m_addr       // Corrected address phase
);

  import ahb_in_pkg::*;

  // ------------------------------
  // Early burst termination
  // ------------------------------

  // Output stage may drop us mid burst, the remaining beats then
  // go out as an undefined length INCR burst
  logic override_q;
  logic override_d;
  logic bound_q;
  logic bound_d;
  logic bound_en;
  logic [3:0] offset;  // Beat index within 16 beats
  logic [3:0] check;   // Offset with bits above wrap length set

  always_comb
  begin
    override_d = override_q;
    if (s_addr.trans == trn_nonseq || s_addr.trans == trn_idle)
    begin
      override_d = 1'b0;  // New burst or end of burst
    end
    else if (s_addr.trans == trn_seq && load && !active_ip)
    begin
      override_d = 1'b1;  // Burst broken by the output stage
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      override_q <= 1'b0;
    end
    else if (HREADYS)
    begin
      override_q <= override_d;
    end
  end

  // ------------------------------
  // Wrap boundary detection
  // ------------------------------

  // Beat number from address, byte to doubleword
  always_comb
  begin
    case (s_addr.size)
      3'b000:  offset = s_addr.addr[3:0];
      3'b001:  offset = s_addr.addr[4:1];
      3'b010:  offset = s_addr.addr[5:2];
      3'b011:  offset = s_addr.addr[6:3];
      default: offset = s_addr.addr[3:0];  // Wider sizes not handled
    endcase
  end

  // Last beat before the wrap has all offset bits of the wrap length set
  always_comb
  begin
    case (s_addr.burst)
      bur_wrap4:  check = {2'b11, offset[1:0]};
      bur_wrap8:  check = {1'b1, offset[2:0]};
      bur_wrap16: check = offset;
      default:    check = 4'b0000;  // Incrementing bursts never wrap
    endcase
  end

  assign bound_d  = &check;
  assign bound_en = s_addr.trans[1] & HREADYS;  // Update on active beats only

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      bound_q <= 1'b0;
    end
    else if (bound_en)
    begin
      bound_q <= bound_d;
    end
  end

  // ------------------------------
  // Output correction
  // ------------------------------

  always_comb
  begin
    m_addr = held_addr;
    if (override_q && held_trans != trn_nonseq)
    begin
      m_addr.burst = bur_incr;  // Length no longer known to the slave
    end
    if (override_q && bound_q)
    begin
      // SEQ to NONSEQ, BUSY to IDLE after the wrap
      m_addr.trans = htrans_e'({held_addr.trans[1], 1'b0});
    end
  end

  // Any accepted NONSEQ ends an override
  a_nonseq_clears_override: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (HREADYS && s_addr.trans == trn_nonseq) |=> !override_q
  );

endmodule

/* src/ahb_pend_ctrl.sv */
module ahb_pend_ctrl (
  input  logic                  HCLK,          // AHB clock
  input  logic                  HRESETn,       // Sync reset, active low
  input  ahb_in_pkg::ahb_addr_t s_addr,        // Live address phase
  input  logic                  HREADYS,       // Bus-wide HREADY
  input  logic                  active_ip,     // Output stage serving this port
  input  ahb_in_pkg::ahb_resp_t m_resp,        // Response of shared slave
  output logic                  load,          // Transfer accepted this cycle
  output logic                  pend,          // In held state
  output logic                  held_tran_ip,  // Request to output stage
  output ahb_in_pkg::ahb_resp_t s_resp         // Response to master
);

  import ahb_in_pkg::*;

  // ------------------------------
  // Transfer decode
  // ------------------------------

  logic        addr_valid;  // Selected and NONSEQ or SEQ
  logic        data_valid;  // Data phase of a valid transfer
  pend_state_e state_q;
  pend_state_e state_d;

  assign addr_valid = s_addr.sel & s_addr.trans[1];  // Bit 1 set for active trans
  assign load       = addr_valid & HREADYS;

  // ------------------------------
  // Pending-transfer FSM
  // ------------------------------

  // Load with output stage busy has priority over completion
  always_comb
  begin
    state_d = state_q;
    if (load && !active_ip)
    begin
      state_d = st_held;
    end
    else if (active_ip && m_resp.ready)
    begin
      state_d = st_pass;  // Held beat driven and done on the slave
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      state_q <= st_pass;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  assign pend         = (state_q == st_held);
  assign held_tran_ip = load | pend;  // Live request or parked request

  // Data phase tracking follows the master pipeline
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_valid <= 1'b0;
    end
    else if (HREADYS)
    begin
      data_valid <= addr_valid;
    end
  end

  // ------------------------------
  // Response mux
  // ------------------------------

  always_comb
  begin
    if (!data_valid)
    begin
      s_resp.ready = 1'b1;      // Idle, busy or not selected
      s_resp.resp  = rsp_okay;
    end
    else if (pend)
    begin
      s_resp.ready = 1'b0;      // Wait states until output stage takes it
      s_resp.resp  = rsp_okay;
    end
    else
    begin
      s_resp = m_resp;          // Shared slave answers directly
    end
  end

  // Held beat always sits in a live data phase of the master
  a_held_has_data: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    pend |-> data_valid
  );

  // Held state is only reached through an accepted transfer
  a_held_after_load: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (!pend ##1 pend) |-> $past(load)
  );

endmodule

/* src/ahb_hold_reg.sv */
module ahb_hold_reg (
  input  logic                  HCLK,        // AHB clock
  input  logic                  HRESETn,     // Sync reset, active low
  input  ahb_in_pkg::ahb_addr_t s_addr,      // Live address phase
  input  logic                  load,        // Capture strobe
  input  logic                  pend,        // Select held copy
  output ahb_in_pkg::ahb_addr_t held_addr,   // Address phase to burst fix
  output ahb_in_pkg::htrans_e   held_trans   // Unmodified trans, live or stored
);

  import ahb_in_pkg::*;

  // ------------------------------
  // Holding register
  // ------------------------------

  ahb_addr_t stored_q;  // Last accepted address phase

  // Every accepted transfer is captured, even when it goes straight through
  // Only the copy made while the output stage is busy is ever selected
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      stored_q.trans <= trn_idle;  // No burst history out of reset
    end
    else if (load)
    begin
      stored_q <= s_addr;
    end
  end

  // ------------------------------
  // Live/held select
  // ------------------------------

  // Held copy is presented as a fresh NONSEQ to the slave
  always_comb
  begin
    if (pend)
    begin
      held_addr       = stored_q;
      held_addr.sel   = 1'b1;        // Still selected, master has moved on
      held_addr.trans = trn_nonseq;  // Restart the transfer on the output
    end
    else
    begin
      held_addr = s_addr;  // Zero latency path
    end
  end

  // Trans before the NONSEQ forcing
  // Tells burst fix whether the held beat was the start of a burst
  always_comb
  begin
    if (pend)
    begin
      held_trans = stored_q.trans;
    end
    else
    begin
      held_trans = s_addr.trans;
    end
  end

endmodule

/* src/ahb_in_pkg.sv */
package ahb_in_pkg;

  // ------------------------------
  // Field widths
  // ------------------------------

  localparam int unsigned addr_w  = 32;  // HADDR width
  localparam int unsigned hsize_w = 3;   // HSIZE width
  localparam int unsigned hprot_w = 4;   // HPROT width

  // ------------------------------
  // AHB encodings
  // ------------------------------

  // HTRANS, bit 1 set means an active transfer
  typedef enum logic [1:0] {
    trn_idle   = 2'b00,  // No transfer
    trn_busy   = 2'b01,  // Master pause inside a burst
    trn_nonseq = 2'b10,  // First beat or single
    trn_seq    = 2'b11   // Following beat of a burst
  } htrans_e;

  // HBURST
  typedef enum logic [2:0] {
    bur_single = 3'b000,
    bur_incr   = 3'b001,  // Undefined length incrementing
    bur_wrap4  = 3'b010,
    bur_incr4  = 3'b011,
    bur_wrap8  = 3'b100,
    bur_incr8  = 3'b101,
    bur_wrap16 = 3'b110,
    bur_incr16 = 3'b111
  } hburst_e;

  // HRESP, AHB2 style with retry and split
  typedef enum logic [1:0] {
    rsp_okay  = 2'b00,
    rsp_error = 2'b01,
    rsp_retry = 2'b10,
    rsp_split = 2'b11
  } hresp_e;

  // Pending-transfer FSM states
  typedef enum logic {
    st_pass = 1'b0,  // Live path to output stage
    st_held = 1'b1   // Transfer parked in holding register
  } pend_state_e;

  // ------------------------------
  // Port bundles
  // ------------------------------

  // Address and control phase
  typedef struct packed {
    logic               sel;       // HSEL
    htrans_e            trans;     // HTRANS
    logic [addr_w-1:0]  addr;      // HADDR
    logic               write;     // HWRITE
    logic [hsize_w-1:0] size;      // HSIZE
    hburst_e            burst;     // HBURST
    logic [hprot_w-1:0] prot;      // HPROT
    logic               mastlock;  // HMASTLOCK
  } ahb_addr_t;

  // Data phase response
  typedef struct packed {
    logic   ready;  // HREADYOUT
    hresp_e resp;   // HRESP
  } ahb_resp_t;

endpackage
